// ==== source/ctrl_cfg.svh ====
//**************************************************
// widths and depths for the processor control unit
// include wherever a port or register width is needed
//**************************************************

`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// one control word per instruction from program ROM
`define CTRL_WORD_W 32

// address and data word width
`define CTRL_ADDR_W 16

// return stack holds 2**8 entries
`define CTRL_STACK_LOG2 8

`define CTRL_STATUS_W 6
`define CTRL_REG_SEL_W 3

`endif

// ==== source/ctrlPkg.sv ====
//**************************************************
// enums shared by the control unit modules
//**************************************************

package ctrlPkg;

  // gaps at 0x09-0x0A and 0x11-0x13 decode as NOP
  typedef enum logic [4:0] {
    opNop = 5'h00, opLdr = 5'h01, opStr = 5'h02, opLpt = 5'h03,
    opSpt = 5'h04, opCmp = 5'h05, opAdd = 5'h06, opSub = 5'h07,
    opMul = 5'h08, opAnd = 5'h0B, opOr  = 5'h0C, opXor = 5'h0D,
    opNot = 5'h0E, opLsl = 5'h0F, opLsr = 5'h10,
    opJmp = 5'h14, opJsr = 5'h15, opRts = 5'h16,
    opJoc = 5'h17, opJsc = 5'h18, opRsc = 5'h19
  } opcode_t;

  // bit 6 enables the ALU, low bits pick the unit
  typedef enum logic [6:0] {
    aluIdle       = 7'h00,
    aluPass       = 7'h40,
    aluCompare    = 7'h60,
    aluAddSub     = 7'h41,
    aluMul        = 7'h42,
    aluLogic      = 7'h44,
    aluShiftLeft  = 7'h48,
    aluShiftRight = 7'h50
  } aluFunc_t;

  typedef enum logic [3:0] {
    busIdle      = 4'h0,
    busAlu       = 4'h1,
    busRam       = 4'h2,
    busDataRom   = 4'h3,
    busGpu       = 4'h4,
    busImmediate = 4'h6
  } busSource_t;

  typedef enum logic [1:0] {pcAdvance, pcJump, pcCall, pcReturn} pcAction_t;

  typedef enum logic {stFetch, stExecute} fetchState_t;

endpackage

// ==== source/returnStack.sv ====
//**************************************************
// return address stack for JSR/RTS
// push writes at the pointer, top is the last pushed entry
//**************************************************

`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module returnStack (
  input  logic                    CLK,
  input  logic                    arstN,
  input  logic                    push,
  input  logic                    pop,
  input  logic [`CTRL_ADDR_W-1:0] pushValue,
  output logic [`CTRL_ADDR_W-1:0] top
);

  localparam int Depth = 1 << `CTRL_STACK_LOG2;

  logic [`CTRL_ADDR_W-1:0]     entries [Depth];
  logic [`CTRL_STACK_LOG2-1:0] stackPtr;
  logic [`CTRL_STACK_LOG2-1:0] belowPtr;

  // pointer wraps modulo the depth
  assign belowPtr = stackPtr - 1'b1;
  assign top = entries[belowPtr];

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
      stackPtr <= '0;
    else if (push)
      stackPtr <= stackPtr + 1'b1;
    else if (pop)
      stackPtr <= belowPtr;
  end

  always_ff @(posedge CLK)
  begin
    if (push)
      entries[stackPtr] <= pushValue;
  end

endmodule

// ==== source/fetchSequencer.sv ====
//**************************************************
// fetch/execute sequencing and the program counter
// PC moves at the edge that ends each execute cycle
//**************************************************

`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module fetchSequencer (
  input  logic                    CLK,
  input  logic                    arstN,
  input  ctrlPkg::pcAction_t      pcAction,
  input  logic [`CTRL_ADDR_W-1:0] branchTarget,
  output logic                    execute,
  output logic [`CTRL_ADDR_W-1:0] progRomAdd
);

  import ctrlPkg::*;

  fetchState_t             state;
  logic [`CTRL_ADDR_W-1:0] pc;
  logic [`CTRL_ADDR_W-1:0] pcPlusOne;
  logic [`CTRL_ADDR_W-1:0] nextPc;
  logic [`CTRL_ADDR_W-1:0] stackTop;
  logic                    push;
  logic                    pop;

  // two cycles per instruction, no stalls
  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
      state <= stFetch;
    else if (state == stFetch)
      state <= stExecute;
    else
      state <= stFetch;
  end

  assign execute = (state == stExecute);
  assign pcPlusOne = pc + 1'b1;

  // return address is the instruction after the call
  assign push = execute && (pcAction == pcCall);
  assign pop = execute && (pcAction == pcReturn);

  always_comb
  begin
    case (pcAction)
      pcJump:   nextPc = branchTarget;
      pcCall:   nextPc = branchTarget;
      pcReturn: nextPc = stackTop;
      default:  nextPc = pcPlusOne;
    endcase
  end

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
      pc <= '0;
    else if (execute)
      pc <= nextPc;
  end

  assign progRomAdd = pc;

  returnStack retStack (
    .CLK       (CLK),
    .arstN     (arstN),
    .push      (push),
    .pop       (pop),
    .pushValue (pcPlusOne),
    .top       (stackTop)
  );

endmodule

// ==== source/instructionDecoder.sv ====
//**************************************************
// control word decode into datapath controls
// outputs register at the end of execute, strobes last one cycle
//**************************************************

`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module instructionDecoder (
  input  logic                       CLK,
  input  logic                       arstN,
  input  logic                       execute,
  input  logic [`CTRL_WORD_W-1:0]    controlWord,
  input  logic [`CTRL_STATUS_W-1:0]  aluStatus,
  output logic [`CTRL_REG_SEL_W-1:0] operand1,
  output logic [`CTRL_REG_SEL_W-1:0] operand2,
  output logic [`CTRL_REG_SEL_W-1:0] results,
  output ctrlPkg::aluFunc_t          aluOperation,
  output logic [3:0]                 aluParams,
  output ctrlPkg::busSource_t        busState,
  output logic                       aluReadBus,
  output logic                       ramWrite,
  output logic                       gpuWrite,
  output logic [`CTRL_ADDR_W-1:0]    dout,
  output ctrlPkg::pcAction_t         pcAction,
  output logic [`CTRL_ADDR_W-1:0]    branchTarget,
  output logic                       ramLoad,
  output logic                       romLoad,
  output logic                       gpuLoad,
  output logic                       fromPointer,
  output logic [`CTRL_ADDR_W-1:0]    immediate
);

  import ctrlPkg::*;

  // control word fields
  logic [1:0]                 variant;
  opcode_t                    opcode;
  logic [`CTRL_REG_SEL_W-1:0] op1Field;
  logic [`CTRL_REG_SEL_W-1:0] op2Field;
  logic [`CTRL_REG_SEL_W-1:0] resultField;
  logic [`CTRL_STATUS_W-1:0]  condMask;
  logic [`CTRL_ADDR_W-1:0]    immField;

  logic                       taken;
  aluFunc_t                   aluSel;
  logic [3:0]                 paramSel;
  pcAction_t                  action;
  logic                       ramSel;
  logic                       romSel;
  logic                       gpuSel;

  // next register values, hold by default
  logic [`CTRL_REG_SEL_W-1:0] nxtOperand1;
  logic [`CTRL_REG_SEL_W-1:0] nxtOperand2;
  logic [`CTRL_REG_SEL_W-1:0] nxtResults;
  aluFunc_t                   nxtAluOp;
  logic [3:0]                 nxtParams;
  busSource_t                 nxtBus;
  logic                       nxtReadBus;
  logic                       nxtRamWrite;
  logic                       nxtGpuWrite;
  logic [`CTRL_ADDR_W-1:0]    nxtDout;

  assign variant = controlWord[1:0];
  assign opcode = opcode_t'(controlWord[6:2]);
  assign op1Field = controlWord[9:7];
  assign op2Field = controlWord[12:10];
  assign resultField = controlWord[15:13];
  assign condMask = controlWord[12:7];
  assign immField = controlWord[31:16];

  assign taken = |(condMask & aluStatus);

  // ALU unit and parameter per arithmetic opcode
  always_comb
  begin
    paramSel = 4'd0;
    case (opcode)
      opCmp:   aluSel = aluCompare;
      opAdd:   aluSel = aluAddSub;
      opSub:
      begin
        aluSel = aluAddSub;
        paramSel = 4'd1;
      end
      opMul:   aluSel = aluMul;
      opAnd:   aluSel = aluLogic;
      opOr:
      begin
        aluSel = aluLogic;
        paramSel = 4'd1;
      end
      opXor:
      begin
        aluSel = aluLogic;
        paramSel = 4'd2;
      end
      opNot:
      begin
        aluSel = aluLogic;
        paramSel = 4'd3;
      end
      opLsl:   aluSel = aluShiftLeft;
      opLsr:   aluSel = aluShiftRight;
      default: aluSel = aluIdle;
    endcase
  end

  always_comb
  begin
    nxtOperand1 = operand1;
    nxtOperand2 = operand2;
    nxtResults = results;
    nxtAluOp = aluIdle;
    nxtParams = aluParams;
    nxtBus = busIdle;
    nxtReadBus = 1'b0;
    nxtRamWrite = 1'b0;
    nxtGpuWrite = 1'b0;
    nxtDout = dout;
    action = pcAdvance;
    ramSel = 1'b0;
    romSel = 1'b0;
    gpuSel = 1'b0;
    fromPointer = 1'b0;
    case (opcode)
      opLdr, opLpt:
      begin
        nxtResults = resultField;
        nxtAluOp = aluPass;
        nxtReadBus = 1'b1;
        fromPointer = (opcode == opLpt);
        case (variant)
          2'd0:
          begin
            nxtBus = busRam;
            ramSel = 1'b1;
          end
          2'd1:
          begin
            nxtBus = busDataRom;
            romSel = 1'b1;
          end
          2'd2:
          begin
            nxtBus = busGpu;
            gpuSel = 1'b1;
          end
          default:
          begin
            // LPT has no pointer for variant 3
            if (opcode == opLdr)
            begin
              nxtBus = busImmediate;
              nxtDout = immField;
            end
          end
        endcase
      end
      opStr:
      begin
        nxtOperand1 = op1Field;
        nxtBus = busAlu;
        ramSel = (variant == 2'd0);
        gpuSel = (variant == 2'd2);
        nxtRamWrite = (variant == 2'd0);
        nxtGpuWrite = (variant == 2'd2);
      end
      opSpt:
      begin
        nxtOperand1 = op1Field;
        nxtBus = variant[1] ? busImmediate : busAlu;
        nxtDout = immField;
        fromPointer = 1'b1;
        ramSel = !variant[0];
        gpuSel = variant[0];
        nxtRamWrite = !variant[0];
        nxtGpuWrite = variant[0];
      end
      opCmp, opAdd, opSub, opMul, opAnd, opOr, opXor, opNot, opLsl, opLsr:
      begin
        nxtOperand1 = op1Field;
        nxtAluOp = aluSel;
        nxtParams = paramSel;
        // compare only updates status
        if (opcode != opCmp)
          nxtResults = resultField;
        case (variant)
          2'd0:
          begin
            nxtReadBus = 1'b1;
            nxtBus = busRam;
            ramSel = 1'b1;
          end
          2'd1:    nxtOperand2 = op2Field;
          2'd2:
          begin
            nxtReadBus = 1'b1;
            nxtBus = busGpu;
            gpuSel = 1'b1;
          end
          default:
          begin
            nxtReadBus = 1'b1;
            nxtBus = busImmediate;
            nxtDout = immField;
          end
        endcase
      end
      opJmp:   action = pcJump;
      opJsr:   action = pcCall;
      opRts:   action = pcReturn;
      opJoc:   action = taken ? pcJump : pcAdvance;
      opJsc:   action = taken ? pcCall : pcAdvance;
      opRsc:   action = taken ? pcReturn : pcAdvance;
      default: ;
    endcase
  end

  assign pcAction = execute ? action : pcAdvance;
  assign branchTarget = immField;
  assign immediate = immField;
  assign ramLoad = execute && ramSel;
  assign romLoad = execute && romSel;
  assign gpuLoad = execute && gpuSel;

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      operand1 <= '0;
      operand2 <= '0;
      results <= '0;
      aluOperation <= aluIdle;
      aluParams <= '0;
      busState <= busIdle;
      aluReadBus <= 1'b0;
      ramWrite <= 1'b0;
      gpuWrite <= 1'b0;
      dout <= '0;
    end
    else if (execute)
    begin
      operand1 <= nxtOperand1;
      operand2 <= nxtOperand2;
      results <= nxtResults;
      aluOperation <= nxtAluOp;
      aluParams <= nxtParams;
      busState <= nxtBus;
      aluReadBus <= nxtReadBus;
      ramWrite <= nxtRamWrite;
      gpuWrite <= nxtGpuWrite;
      dout <= nxtDout;
    end
    else
    begin
      // write strobes drop after their one cycle
      ramWrite <= 1'b0;
      gpuWrite <= 1'b0;
    end
  end

endmodule

// ==== source/addressPointers.sv ====
//**************************************************
// RAM, data-ROM and GPU address pointers
// loaded from the immediate or from freg/greg/hreg
//**************************************************

`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module addressPointers (
  input  logic                    CLK,
  input  logic                    arstN,
  input  logic                    ramLoad,
  input  logic                    romLoad,
  input  logic                    gpuLoad,
  input  logic                    fromPointer,
  input  logic [`CTRL_ADDR_W-1:0] immediate,
  input  logic [`CTRL_ADDR_W-1:0] freg,
  input  logic [`CTRL_ADDR_W-1:0] greg,
  input  logic [`CTRL_ADDR_W-1:0] hreg,
  output logic [`CTRL_ADDR_W-1:0] ramAdd,
  output logic [`CTRL_ADDR_W-1:0] dataRomAdd,
  output logic [`CTRL_ADDR_W-1:0] gpuAdd
);

  // index 0 ram, 1 data rom, 2 gpu
  logic [2:0]              loadVec;
  logic [`CTRL_ADDR_W-1:0] ptrSrc [3];
  logic [`CTRL_ADDR_W-1:0] ptrReg [3];

  assign loadVec = {gpuLoad, romLoad, ramLoad};
  assign ptrSrc[0] = freg;
  assign ptrSrc[1] = greg;
  assign ptrSrc[2] = hreg;

  for (genvar i = 0; i < 3; i++)
  begin : gPtr
    always_ff @(posedge CLK or negedge arstN)
    begin
      if (!arstN)
        ptrReg[i] <= '0;
      else if (loadVec[i])
        ptrReg[i] <= fromPointer ? ptrSrc[i] : immediate;
    end
  end

  assign ramAdd = ptrReg[0];
  assign dataRomAdd = ptrReg[1];
  assign gpuAdd = ptrReg[2];

endmodule

// ==== source/controlTop.sv ====
//**************************************************
// control unit top level
// sequencer, decoder and address pointers
//**************************************************

`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module controlTop (
  input  logic                       CLK,
  input  logic                       arstN,
  input  logic [`CTRL_WORD_W-1:0]    controlWord,
  input  logic [`CTRL_STATUS_W-1:0]  aluStatus,
  input  logic [`CTRL_ADDR_W-1:0]    freg,
  input  logic [`CTRL_ADDR_W-1:0]    greg,
  input  logic [`CTRL_ADDR_W-1:0]    hreg,
  output logic [`CTRL_ADDR_W-1:0]    progRomAdd,
  output logic [`CTRL_ADDR_W-1:0]    ramAdd,
  output logic [`CTRL_ADDR_W-1:0]    dataRomAdd,
  output logic [`CTRL_ADDR_W-1:0]    gpuAdd,
  output logic [`CTRL_REG_SEL_W-1:0] operand1,
  output logic [`CTRL_REG_SEL_W-1:0] operand2,
  output logic [`CTRL_REG_SEL_W-1:0] results,
  output ctrlPkg::aluFunc_t          aluOperation,
  output logic [3:0]                 aluParams,
  output ctrlPkg::busSource_t        busState,
  output logic                       aluReadBus,
  output logic                       ramWrite,
  output logic                       gpuWrite,
  output logic [`CTRL_ADDR_W-1:0]    dout
);

  import ctrlPkg::*;

  logic                    execute;
  pcAction_t               pcAction;
  logic [`CTRL_ADDR_W-1:0] branchTarget;
  logic                    ramLoad;
  logic                    romLoad;
  logic                    gpuLoad;
  logic                    fromPointer;
  logic [`CTRL_ADDR_W-1:0] immediate;

  fetchSequencer fetchSeq (
    .CLK          (CLK),
    .arstN        (arstN),
    .pcAction     (pcAction),
    .branchTarget (branchTarget),
    .execute      (execute),
    .progRomAdd   (progRomAdd)
  );

  instructionDecoder decoder (
    .CLK          (CLK),
    .arstN        (arstN),
    .execute      (execute),
    .controlWord  (controlWord),
    .aluStatus    (aluStatus),
    .operand1     (operand1),
    .operand2     (operand2),
    .results      (results),
    .aluOperation (aluOperation),
    .aluParams    (aluParams),
    .busState     (busState),
    .aluReadBus   (aluReadBus),
    .ramWrite     (ramWrite),
    .gpuWrite     (gpuWrite),
    .dout         (dout),
    .pcAction     (pcAction),
    .branchTarget (branchTarget),
    .ramLoad      (ramLoad),
    .romLoad      (romLoad),
    .gpuLoad      (gpuLoad),
    .fromPointer  (fromPointer),
    .immediate    (immediate)
  );

  addressPointers pointers (
    .CLK         (CLK),
    .arstN       (arstN),
    .ramLoad     (ramLoad),
    .romLoad     (romLoad),
    .gpuLoad     (gpuLoad),
    .fromPointer (fromPointer),
    .immediate   (immediate),
    .freg        (freg),
    .greg        (greg),
    .hreg        (hreg),
    .ramAdd      (ramAdd),
    .dataRomAdd  (dataRomAdd),
    .gpuAdd      (gpuAdd)
  );

endmodule

// ==== sim/controlTop_assert.sv ====
//**************************************************
// bound checker for controlTop, a reference model of each instruction
// compared with the DUT outputs in the cycle after execute
//**************************************************

`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module controlTopChecker (
  input logic                       CLK,
  input logic                       arstN,
  input logic                       execute,
  input logic [`CTRL_WORD_W-1:0]    controlWord,
  input logic [`CTRL_STATUS_W-1:0]  aluStatus,
  input logic [`CTRL_ADDR_W-1:0]    freg,
  input logic [`CTRL_ADDR_W-1:0]    greg,
  input logic [`CTRL_ADDR_W-1:0]    hreg,
  input logic [`CTRL_ADDR_W-1:0]    progRomAdd,
  input logic [`CTRL_ADDR_W-1:0]    ramAdd,
  input logic [`CTRL_ADDR_W-1:0]    dataRomAdd,
  input logic [`CTRL_ADDR_W-1:0]    gpuAdd,
  input logic [`CTRL_REG_SEL_W-1:0] operand1,
  input logic [`CTRL_REG_SEL_W-1:0] operand2,
  input logic [`CTRL_REG_SEL_W-1:0] results,
  input logic [6:0]                 aluOperation,
  input logic [3:0]                 aluParams,
  input logic [3:0]                 busState,
  input logic                       aluReadBus,
  input logic                       ramWrite,
  input logic                       gpuWrite,
  input logic [`CTRL_ADDR_W-1:0]    dout
);

  import ctrlPkg::*;

  int errCount;

  logic [4:0]                 op;
  logic [1:0]                 variant;
  logic [`CTRL_ADDR_W-1:0]    imm;
  logic                       taken;
  logic                       checkValid;
  logic [`CTRL_ADDR_W-1:0]    expPc;
  logic [`CTRL_ADDR_W-1:0]    expRam;
  logic [`CTRL_ADDR_W-1:0]    expRom;
  logic [`CTRL_ADDR_W-1:0]    expGpu;
  logic [`CTRL_REG_SEL_W-1:0] expOp1;
  logic [`CTRL_REG_SEL_W-1:0] expOp2;
  logic [`CTRL_REG_SEL_W-1:0] expRes;
  logic [6:0]                 expAluOp;
  logic [3:0]                 expParams;
  logic [3:0]                 expBus;
  logic                       expReadBus;
  logic                       expRamW;
  logic                       expGpuW;
  logic [`CTRL_ADDR_W-1:0]    expDout;
  logic [`CTRL_ADDR_W-1:0]    stackMem [256];
  logic [7:0]                 sp;

  assign op = controlWord[6:2];
  assign variant = controlWord[1:0];
  assign imm = controlWord[31:16];
  assign taken = |(controlWord[12:7] & aluStatus);

  // ALU function in the upper bits, parameter in the low nibble
  function automatic logic [10:0] aluEntry(input logic [4:0] code);
    case (code)
      opCmp:   return {aluCompare, 4'd0};
      opAdd:   return {aluAddSub, 4'd0};
      opSub:   return {aluAddSub, 4'd1};
      opMul:   return {aluMul, 4'd0};
      opAnd:   return {aluLogic, 4'd0};
      opOr:    return {aluLogic, 4'd1};
      opXor:   return {aluLogic, 4'd2};
      opNot:   return {aluLogic, 4'd3};
      opLsl:   return {aluShiftLeft, 4'd0};
      default: return {aluShiftRight, 4'd0};
    endcase
  endfunction

  // later nonblocking writes override the defaults at the top
  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      checkValid <= 1'b0;
      expPc <= '0;
      {expRam, expRom, expGpu} <= '0;
      {expOp1, expOp2, expRes, expParams, expDout} <= '0;
      expAluOp <= aluIdle;
      expBus <= busIdle;
      {expReadBus, expRamW, expGpuW} <= '0;
      sp <= '0;
    end
    else
    begin
      checkValid <= execute;
      if (execute)
      begin
        expPc <= expPc + 1'b1;
        expAluOp <= aluIdle;
        expBus <= busIdle;
        {expReadBus, expRamW, expGpuW} <= '0;
        if (op == opLdr || op == opLpt)
        begin
          expRes <= controlWord[15:13];
          expAluOp <= aluPass;
          expReadBus <= 1'b1;
          case (variant)
            2'd0:
            begin
              expBus <= busRam;
              expRam <= (op == opLpt) ? freg : imm;
            end
            2'd1:
            begin
              expBus <= busDataRom;
              expRom <= (op == opLpt) ? greg : imm;
            end
            2'd2:
            begin
              expBus <= busGpu;
              expGpu <= (op == opLpt) ? hreg : imm;
            end
            default:
            begin
              if (op == opLdr)
              begin
                expBus <= busImmediate;
                expDout <= imm;
              end
            end
          endcase
        end
        else if (op == opStr)
        begin
          expOp1 <= controlWord[9:7];
          expBus <= busAlu;
          expRamW <= (variant == 2'd0);
          expGpuW <= (variant == 2'd2);
          if (variant == 2'd0)
            expRam <= imm;
          if (variant == 2'd2)
            expGpu <= imm;
        end
        else if (op == opSpt)
        begin
          expOp1 <= controlWord[9:7];
          expBus <= variant[1] ? busImmediate : busAlu;
          expDout <= imm;
          expRamW <= !variant[0];
          expGpuW <= variant[0];
          if (variant[0])
            expGpu <= hreg;
          else
            expRam <= freg;
        end
        else if (op inside {opCmp, opAdd, opSub, opMul, opAnd, opOr, opXor, opNot,
                            opLsl, opLsr})
        begin
          expOp1 <= controlWord[9:7];
          {expAluOp, expParams} <= aluEntry(op);
          if (op != opCmp)
            expRes <= controlWord[15:13];
          expReadBus <= (variant != 2'd1);
          case (variant)
            2'd0:
            begin
              expBus <= busRam;
              expRam <= imm;
            end
            2'd1:    expOp2 <= controlWord[12:10];
            2'd2:
            begin
              expBus <= busGpu;
              expGpu <= imm;
            end
            default:
            begin
              expBus <= busImmediate;
              expDout <= imm;
            end
          endcase
        end
        else if (op == opJmp || (op == opJoc && taken))
          expPc <= imm;
        else if (op == opJsr || (op == opJsc && taken))
        begin
          expPc <= imm;
          stackMem[sp] <= expPc + 1'b1;
          sp <= sp + 1'b1;
        end
        else if (op == opRts || (op == opRsc && taken))
        begin
          expPc <= stackMem[sp - 1'b1];
          sp <= sp - 1'b1;
        end
      end
    end
  end

  resetState: assert property (@(posedge CLK) $rose(arstN) |->
      progRomAdd == '0 && !ramWrite && !gpuWrite && aluOperation == aluIdle &&
      busState == busIdle)
    else
    begin
      errCount++;
      $error("reset state wrong after reset release");
    end

  nextAddress: assert property (@(posedge CLK) disable iff (!arstN)
      checkValid |-> progRomAdd == expPc)
    else
    begin
      errCount++;
      $error("MISMATCH nextAddress expected %h actual %h",
             $sampled(expPc), $sampled(progRomAdd));
    end

  registerSelects: assert property (@(posedge CLK) disable iff (!arstN)
      checkValid |-> {operand1, operand2, results} == {expOp1, expOp2, expRes})
    else
    begin
      errCount++;
      $error("MISMATCH registerSelects expected %h actual %h",
             $sampled({expOp1, expOp2, expRes}), $sampled({operand1, operand2, results}));
    end

  aluControl: assert property (@(posedge CLK) disable iff (!arstN)
      checkValid |-> {aluOperation, aluParams, aluReadBus} == {expAluOp, expParams, expReadBus})
    else
    begin
      errCount++;
      $error("MISMATCH aluControl expected %h actual %h",
             $sampled({expAluOp, expParams, expReadBus}),
             $sampled({aluOperation, aluParams, aluReadBus}));
    end

  busAndData: assert property (@(posedge CLK) disable iff (!arstN)
      checkValid |-> busState == expBus && dout == expDout)
    else
    begin
      errCount++;
      $error("MISMATCH busAndData expected %h actual %h",
             $sampled({expBus, expDout}), $sampled({busState, dout}));
    end

  pointerValues: assert property (@(posedge CLK) disable iff (!arstN)
      checkValid |-> {ramAdd, dataRomAdd, gpuAdd} == {expRam, expRom, expGpu})
    else
    begin
      errCount++;
      $error("MISMATCH pointerValues expected %h actual %h",
             $sampled({expRam, expRom, expGpu}), $sampled({ramAdd, dataRomAdd, gpuAdd}));
    end

  writeStrobes: assert property (@(posedge CLK) disable iff (!arstN)
      checkValid |-> {ramWrite, gpuWrite} == {expRamW, expGpuW})
    else
    begin
      errCount++;
      $error("MISMATCH writeStrobes expected %b actual %b",
             $sampled({expRamW, expGpuW}), $sampled({ramWrite, gpuWrite}));
    end

  // a strobe never survives into the next execute cycle
  strobeWidth: assert property (@(posedge CLK) disable iff (!arstN)
      execute |-> !ramWrite && !gpuWrite)
    else
    begin
      errCount++;
      $error("write strobe stayed high for more than one cycle");
    end

endmodule

// ==== sim/controlTb.sv ====
//**************************************************
// testbench for controlTop with a program ROM model
// the bound checker does the comparing, this drives and reports
//**************************************************

`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module controlTb;

  import ctrlPkg::*;

  localparam int EndAddr = 200;
  localparam int MaxInstr = 90;
  localparam int CycleLimit = 2 * MaxInstr + 40;

  logic                       CLK;
  logic                       arstN;
  logic [`CTRL_WORD_W-1:0]    controlWord;
  logic [`CTRL_STATUS_W-1:0]  aluStatus;
  logic [`CTRL_ADDR_W-1:0]    freg;
  logic [`CTRL_ADDR_W-1:0]    greg;
  logic [`CTRL_ADDR_W-1:0]    hreg;
  logic [`CTRL_ADDR_W-1:0]    progRomAdd;
  logic [`CTRL_ADDR_W-1:0]    ramAdd;
  logic [`CTRL_ADDR_W-1:0]    dataRomAdd;
  logic [`CTRL_ADDR_W-1:0]    gpuAdd;
  logic [`CTRL_REG_SEL_W-1:0] operand1;
  logic [`CTRL_REG_SEL_W-1:0] operand2;
  logic [`CTRL_REG_SEL_W-1:0] results;
  aluFunc_t                   aluOperation;
  logic [3:0]                 aluParams;
  busSource_t                 busState;
  logic                       aluReadBus;
  logic                       ramWrite;
  logic                       gpuWrite;
  logic [`CTRL_ADDR_W-1:0]    dout;

  logic [`CTRL_WORD_W-1:0] rom [256];
  int cycles;
  int errors;
  int timeouts;

  controlTop DUT (.*);

  bind controlTop controlTopChecker chk (.*);

  always #10 CLK = ~CLK;

  always @(posedge CLK)
    cycles <= cycles + 1;

  function automatic logic [31:0] encode(input opcode_t op, input logic [1:0] variant,
                                         input logic [2:0] op1, input logic [2:0] op2,
                                         input logic [2:0] res, input logic [15:0] imm);
    return {imm, res, op2, op1, op, variant};
  endfunction

  // the condition mask sits on the operand fields
  function automatic logic [31:0] condWord(input opcode_t op, input logic [5:0] mask,
                                           input logic [15:0] imm);
    return encode(op, 2'd0, mask[2:0], mask[5:3], 3'd0, imm);
  endfunction

  task automatic loadProgram();
    opcode_t aluOps [10] = '{opCmp, opAdd, opSub, opMul, opAnd, opOr, opXor, opNot,
                             opLsl, opLsr};
    int addr;
    // NOPs carrying their own address in the immediate
    for (int a = 0; a < 256; a++)
      rom[a] = {a[15:0], 16'h0000};
    rom[1] = {16'h0001, 9'd0, 5'h09, 2'd0};
    for (int v = 0; v < 4; v++)
    begin
      rom[2 + v] = encode(opLdr, v[1:0], 3'd0, 3'd0, 3'(v + 1), 16'h1200 + 16'(v));
      rom[6 + v] = encode(opLpt, v[1:0], 3'd0, 3'd0, 3'(v + 4), 16'h0);
      rom[13 + v] = encode(opSpt, v[1:0], 3'(v), 3'd0, 3'd0, 16'h5500 + 16'(v));
    end
    rom[10] = encode(opStr, 2'd0, 3'd2, 3'd0, 3'd0, 16'h0100);
    rom[11] = encode(opStr, 2'd2, 3'd3, 3'd0, 3'd0, 16'h0200);
    rom[12] = encode(opStr, 2'd1, 3'd4, 3'd0, 3'd0, 16'h0300);
    addr = 17;
    for (int i = 0; i < 10; i++)
      for (int v = 0; v < 4; v++)
      begin
        rom[addr] = encode(aluOps[i], v[1:0], 3'(i), 3'(7 - i), 3'(v + 2),
                           16'hA000 + 16'(addr));
        addr++;
      end
    rom[57] = condWord(opJmp, 6'h00, 16'd60);
    rom[60] = condWord(opJoc, 6'h00, 16'd70);
    rom[61] = condWord(opJoc, 6'h3F, 16'd64);
    rom[64] = condWord(opJsr, 6'h00, 16'd100);
    rom[65] = condWord(opJsc, 6'h3F, 16'd110);
    rom[66] = condWord(opJsc, 6'h00, 16'd120);
    rom[67] = condWord(opRsc, 6'h00, 16'd0);
    rom[68] = condWord(opJmp, 6'h00, 16'd150);
    // nested call from the first subroutine
    rom[100] = condWord(opJsr, 6'h00, 16'd105);
    rom[101] = condWord(opRts, 6'h00, 16'd0);
    rom[106] = condWord(opRts, 6'h00, 16'd0);
    rom[110] = condWord(opRsc, 6'h3F, 16'd0);
    rom[111] = condWord(opRts, 6'h00, 16'd0);
    // single-bit masks so taken and not taken both occur
    for (int b = 0; b < 6; b++)
      rom[150 + 2 * b] = condWord(opJoc, 6'(1 << b), 16'(152 + 2 * b));
    rom[162] = condWord(opJmp, 6'h00, 16'(EndAddr));
  endtask

  // new status and pointer registers once per instruction
  always @(posedge CLK)
  begin
    controlWord <= rom[progRomAdd[7:0]];
    if (!DUT.execute)
    begin
      aluStatus <= 6'($urandom);
      freg <= 16'($urandom);
      greg <= 16'($urandom);
      hreg <= 16'($urandom);
    end
  end

  initial
  begin
    void'($urandom(32'h6a551d5e));
    CLK = 1'b0;
    arstN = 1'b0;
    controlWord = '0;
    aluStatus = '0;
    freg = '0;
    greg = '0;
    hreg = '0;
    cycles = 0;
    timeouts = 0;
    loadProgram();
    repeat (3) @(posedge CLK);
    arstN <= 1'b1;
    while (progRomAdd != EndAddr && cycles < CycleLimit)
      @(posedge CLK);
    if (cycles >= CycleLimit)
    begin
      timeouts = 1;
      $display("timeout: the program did not reach its end address in %0d cycles",
               CycleLimit);
    end
    // let the last instruction's checks run
    repeat (3) @(posedge CLK);
    errors = DUT.chk.errCount;
    $display("errors=%0d timeouts=%0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+source
source/ctrlPkg.sv
source/returnStack.sv
source/fetchSequencer.sv
source/instructionDecoder.sv
source/addressPointers.sv
source/controlTop.sv
sim/controlTop_assert.sv
sim/controlTb.sv

// ==== Makefile ====
# Verilator build and run for the control unit testbench

VERILATOR ?= verilator
TOP       ?= controlTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv) list.f
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
